// File: group_norm.f
hw/gn_pkg.sv
hw/beat_fifo.sv
hw/group_accum.sv
hw/isqrt_seq.sv
hw/group_norm_2d.sv
hw/gn_affine.sv
hw/group_norm_top.sv
test/group_norm_chk.sv
test/group_norm_tb.sv

// File: hw/beat_fifo.sv
/*
  Register-array FIFO. DEPTH must be 2 or more.
  in_ready depends only on the fill level.
*/
`timescale 1ns/1ns

module beat_fifo #(
  parameter type T     = gn_pkg::beat_t,
  parameter int  DEPTH = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  T     in_data,
  input  logic in_valid,
  output logic in_ready,
  output T     out_data,
  output logic out_valid,
  input  logic out_ready
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wptr;
  logic [AW-1:0] rptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  assign in_ready  = (count != CW'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      end
      if (pop) begin
        rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      end
      // Simultaneous push and pop leaves the level unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hw/gn_affine.sv
/*
  Per-group gamma/beta over APB, zero wait states, at most 64 groups.
  Group index comes from the count of accepted beats.
*/
`timescale 1ns/1ns

module gn_affine #(
  parameter int NUM_GROUPS  = 4,
  parameter int GROUP_BEATS = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  gn_pkg::beat_t    in_beat,
  input  logic             in_valid,
  output logic             in_ready,
  output gn_pkg::beat_t    out_beat,
  output logic             out_valid,
  input  logic             out_ready,
  input  gn_pkg::apb_req_t apb_req,
  output gn_pkg::apb_rsp_t apb_rsp
);

  import gn_pkg::*;

  localparam int    GRP_W     = (NUM_GROUPS > 1) ? $clog2(NUM_GROUPS) : 1;
  localparam int    CNT_W     = $clog2(GROUP_BEATS + 1);
  localparam data_t GAMMA_ONE = data_t'(1 << FRAC_W);

  data_t            gamma [NUM_GROUPS];
  data_t            beta  [NUM_GROUPS];
  logic [5:0]       reg_idx;
  logic [GRP_W-1:0] reg_sel;
  logic             addr_ok;
  logic             access;
  logic [GRP_W-1:0] grp;
  logic [CNT_W-1:0] beat_cnt;
  logic             in_fire;

  // x * gamma in Q8.8, back to Q4.4 by floor, then add beta
  function automatic data_t affine_lane(input data_t x, input data_t g, input data_t b);
    logic signed [2*DATA_W-1:0]      prod;
    logic signed [2*DATA_W-FRAC_W:0] acc;
    prod = x * g;
    acc  = $signed(prod[2*DATA_W-1:FRAC_W]) + b;
    return sat_data(acc);
  endfunction

  // One word per group at byte address 4*g
  assign reg_idx = apb_req.paddr[7:2];
  assign reg_sel = reg_idx[GRP_W-1:0];
  assign addr_ok = (reg_idx < NUM_GROUPS);
  assign access  = apb_req.psel && apb_req.penable;

  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && !addr_ok;
  assign apb_rsp.prdata  = (apb_req.psel && addr_ok) ?
                           {16'h0, beta[reg_sel], gamma[reg_sel]} : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int g = 0; g < NUM_GROUPS; g++) begin
        gamma[g] <= GAMMA_ONE;
        beta[g]  <= '0;
      end
    end else if (access && apb_req.pwrite && addr_ok) begin
      gamma[reg_sel] <= apb_req.pwdata[DATA_W-1:0];
      beta[reg_sel]  <= apb_req.pwdata[2*DATA_W-1:DATA_W];
    end
  end

  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt  <= '0;
      grp       <= '0;
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
      if (beat_cnt == CNT_W'(GROUP_BEATS - 1)) begin
        beat_cnt <= '0;
        grp      <= (grp == GRP_W'(NUM_GROUPS - 1)) ? '0 : grp + 1'b1;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      for (int i = 0; i < LANES; i++) begin
        out_beat[i] <= affine_lane(in_beat[i], gamma[grp], beta[grp]);
      end
    end
  end

endmodule

// File: hw/gn_pkg.sv
/*
  Widths and types shared by the group normaliser. Data is signed Q4.4.
  The APB address is a byte address with one 32-bit word per group.
*/
package gn_pkg;

  localparam int LANES      = 4;
  localparam int DATA_W     = 8;
  localparam int FRAC_W     = 4;
  localparam int DIFF_W     = DATA_W + 1;
  localparam int VAR_W      = 17;
  localparam int ISQRT_W    = 12;
  localparam int ISQRT_FRAC = 8;

  localparam int DATA_MAX = 2 ** (DATA_W - 1) - 1;
  localparam int DATA_MIN = -(2 ** (DATA_W - 1));

  typedef logic signed [DATA_W-1:0] data_t;
  typedef data_t [LANES-1:0] beat_t;

  // x minus mean, still 4 fraction bits
  typedef logic signed [DIFF_W-1:0] diff_t;
  typedef diff_t [LANES-1:0] diff_beat_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Clamp a wide signed value into the data range
  function automatic data_t sat_data(input logic signed [31:0] v);
    if (v > DATA_MAX) begin
      return data_t'(DATA_MAX);
    end
    if (v < DATA_MIN) begin
      return data_t'(DATA_MIN);
    end
    return v[DATA_W-1:0];
  endfunction

endpackage

// File: hw/group_accum.sv
/*
  Sums the signed lanes of COUNT beats into one total.
  No new beat is taken while the total waits to be read.
*/
`timescale 1ns/1ns

module group_accum #(
  parameter int IN_W  = 8,
  parameter int COUNT = 4
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [gn_pkg::LANES*IN_W-1:0]                     in_lanes,
  input  logic                                              in_valid,
  output logic                                              in_ready,
  output logic signed [IN_W+$clog2(gn_pkg::LANES*COUNT)-1:0] sum,
  output logic                                              sum_valid,
  input  logic                                              sum_ready
);

  import gn_pkg::*;

  localparam int SUM_W = IN_W + $clog2(LANES * COUNT);
  localparam int CNT_W = $clog2(COUNT + 1);

  logic signed [SUM_W-1:0] beat_sum;
  logic [CNT_W-1:0]        beat_cnt;
  logic                    in_fire;

  // Lane adder, each slice sign extended
  always_comb begin
    beat_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      beat_sum = beat_sum + $signed(in_lanes[i*IN_W +: IN_W]);
    end
  end

  assign in_ready = !sum_valid;
  assign in_fire  = in_valid && in_ready;

  // The running sum doubles as the held result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum       <= '0;
      sum_valid <= 1'b0;
      beat_cnt  <= '0;
    end else if (in_fire) begin
      sum <= sum + beat_sum;
      if (beat_cnt == CNT_W'(COUNT - 1)) begin
        beat_cnt  <= '0;
        sum_valid <= 1'b1;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end else if (sum_valid && sum_ready) begin
      sum       <= '0;
      sum_valid <= 1'b0;
    end
  end

endmodule

// File: hw/group_norm_2d.sv
/*
  Two-pass group normaliser over GROUP_BEATS beats, a power of two.
  Input and diff FIFOs hold two groups, which bounds the groups in flight.
*/
`timescale 1ns/1ns

module group_norm_2d #(
  parameter int GROUP_BEATS = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  gn_pkg::beat_t in_beat,
  input  logic          in_valid,
  output logic          in_ready,
  output gn_pkg::beat_t out_beat,
  output logic          out_valid,
  input  logic          out_ready
);

  import gn_pkg::*;

  localparam int LOG2N      = $clog2(LANES * GROUP_BEATS);
  localparam int SUM_W      = DATA_W + LOG2N;
  localparam int SQ_W       = 2 * DIFF_W;
  localparam int SQ_SUM_W   = SQ_W + LOG2N;
  localparam int CNT_W      = $clog2(GROUP_BEATS + 1);
  localparam int FIFO_DEPTH = 2 * GROUP_BEATS;

  logic                    ififo_in_valid;
  logic                    ififo_in_ready;
  beat_t                   ififo_out;
  logic                    ififo_out_valid;
  logic                    ififo_out_ready;
  logic                    sacc_in_valid;
  logic                    sacc_in_ready;
  logic signed [SUM_W-1:0] grp_sum;
  logic                    grp_sum_valid;
  logic                    grp_sum_ready;

  data_t                   mean;
  logic                    mean_valid;
  logic [CNT_W-1:0]        mean_cnt;
  diff_beat_t              diff;
  logic                    diff_fire;

  logic                    dfifo_in_ready;
  diff_beat_t              dfifo_out;
  logic                    dfifo_out_valid;
  logic                    dfifo_out_ready;
  logic [LANES*SQ_W-1:0]   sq_lanes;
  logic                    sq_valid;
  logic                    sq_ready;
  logic                    sqacc_in_ready;
  logic signed [SQ_SUM_W-1:0] sq_sum;
  logic                    sq_sum_valid;
  logic                    sq_sum_ready;

  logic [ISQRT_W-1:0]      isqrt;
  logic                    isqrt_valid;
  logic                    isqrt_ready;
  logic [ISQRT_W-1:0]      r_hold;
  logic                    r_valid;
  logic [CNT_W-1:0]        r_cnt;
  logic                    out_free;
  logic                    norm_fire;
  beat_t                   norm_beat;

  // diff * r, drop the isqrt fraction, clamp to Q4.4
  function automatic data_t norm_lane(input diff_t d, input logic [ISQRT_W-1:0] r);
    logic signed [DIFF_W+ISQRT_W:0] prod;
    prod = d * $signed({1'b0, r});
    return sat_data($signed(prod[DIFF_W+ISQRT_W:ISQRT_FRAC]));
  endfunction

  // Input fork into FIFO and sum accumulator
  assign in_ready       = ififo_in_ready && sacc_in_ready;
  assign ififo_in_valid = in_valid && sacc_in_ready;
  assign sacc_in_valid  = in_valid && ififo_in_ready;

  beat_fifo #(
    .T     (beat_t),
    .DEPTH (FIFO_DEPTH)
  ) i_in_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_beat),
    .in_valid  (ififo_in_valid),
    .in_ready  (ififo_in_ready),
    .out_data  (ififo_out),
    .out_valid (ififo_out_valid),
    .out_ready (ififo_out_ready)
  );

  group_accum #(
    .IN_W  (DATA_W),
    .COUNT (GROUP_BEATS)
  ) i_sum_acc (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_lanes  (in_beat),
    .in_valid  (sacc_in_valid),
    .in_ready  (sacc_in_ready),
    .sum       (grp_sum),
    .sum_valid (grp_sum_valid),
    .sum_ready (grp_sum_ready)
  );

  // Mean is the floor of sum / N, held for one group of diffs
  assign grp_sum_ready = !mean_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mean       <= '0;
      mean_valid <= 1'b0;
      mean_cnt   <= '0;
    end else if (grp_sum_valid && grp_sum_ready) begin
      mean       <= grp_sum[LOG2N +: DATA_W];
      mean_valid <= 1'b1;
      mean_cnt   <= '0;
    end else if (diff_fire) begin
      if (mean_cnt == CNT_W'(GROUP_BEATS - 1)) begin
        mean_valid <= 1'b0;
      end else begin
        mean_cnt <= mean_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      diff[i] = ififo_out[i] - mean;
    end
  end

  // Diff fork into diff FIFO and squaring register
  assign ififo_out_ready = mean_valid && dfifo_in_ready && sq_ready;
  assign diff_fire       = ififo_out_valid && ififo_out_ready;

  beat_fifo #(
    .T     (diff_beat_t),
    .DEPTH (FIFO_DEPTH)
  ) i_diff_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (diff),
    .in_valid  (diff_fire),
    .in_ready  (dfifo_in_ready),
    .out_data  (dfifo_out),
    .out_valid (dfifo_out_valid),
    .out_ready (dfifo_out_ready)
  );

  assign sq_ready = !sq_valid || sqacc_in_ready;

  always_ff @(posedge clk) begin
    if (diff_fire) begin
      for (int i = 0; i < LANES; i++) begin
        sq_lanes[i*SQ_W +: SQ_W] <= diff[i] * diff[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sq_valid <= 1'b0;
    end else if (diff_fire) begin
      sq_valid <= 1'b1;
    end else if (sqacc_in_ready) begin
      sq_valid <= 1'b0;
    end
  end

  group_accum #(
    .IN_W  (SQ_W),
    .COUNT (GROUP_BEATS)
  ) i_sq_acc (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_lanes  (sq_lanes),
    .in_valid  (sq_valid),
    .in_ready  (sqacc_in_ready),
    .sum       (sq_sum),
    .sum_valid (sq_sum_valid),
    .sum_ready (sq_sum_ready)
  );

  // Variance is the slice above the divide-by-N bits
  isqrt_seq i_isqrt (
    .clk       (clk),
    .rst_n     (rst_n),
    .var_in    (sq_sum[LOG2N +: VAR_W]),
    .in_valid  (sq_sum_valid),
    .in_ready  (sq_sum_ready),
    .isqrt     (isqrt),
    .out_valid (isqrt_valid),
    .out_ready (isqrt_ready)
  );

  assign isqrt_ready = !r_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_hold  <= '0;
      r_valid <= 1'b0;
      r_cnt   <= '0;
    end else if (isqrt_valid && isqrt_ready) begin
      r_hold  <= isqrt;
      r_valid <= 1'b1;
      r_cnt   <= '0;
    end else if (norm_fire) begin
      if (r_cnt == CNT_W'(GROUP_BEATS - 1)) begin
        r_valid <= 1'b0;
      end else begin
        r_cnt <= r_cnt + 1'b1;
      end
    end
  end

  // Normalise and register the output beat
  assign out_free        = !out_valid || out_ready;
  assign dfifo_out_ready = r_valid && out_free;
  assign norm_fire       = dfifo_out_valid && dfifo_out_ready;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      norm_beat[i] = norm_lane(dfifo_out[i], r_hold);
    end
  end

  always_ff @(posedge clk) begin
    if (norm_fire) begin
      out_beat <= norm_beat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (norm_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

endmodule

// File: hw/group_norm_top.sv
/*
  Group normaliser followed by the per-group affine stage.
  GROUP_BEATS must be a power of two.
*/
`timescale 1ns/1ns

module group_norm_top #(
  parameter int GROUP_BEATS = 4,
  parameter int NUM_GROUPS  = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  gn_pkg::beat_t    in_beat,
  input  logic             in_valid,
  output logic             in_ready,
  output gn_pkg::beat_t    out_beat,
  output logic             out_valid,
  input  logic             out_ready,
  input  gn_pkg::apb_req_t apb_req,
  output gn_pkg::apb_rsp_t apb_rsp
);

  import gn_pkg::*;

  beat_t norm_beat;
  logic  norm_valid;
  logic  norm_ready;

  group_norm_2d #(
    .GROUP_BEATS (GROUP_BEATS)
  ) i_norm (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (norm_beat),
    .out_valid (norm_valid),
    .out_ready (norm_ready)
  );

  gn_affine #(
    .NUM_GROUPS  (NUM_GROUPS),
    .GROUP_BEATS (GROUP_BEATS)
  ) i_affine (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_beat   (norm_beat),
    .in_valid  (norm_valid),
    .in_ready  (norm_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp)
  );

endmodule

// File: hw/isqrt_seq.sv
/*
  Exact inverse square root by bit search, MSB first, one bit per clock.
  Result is the largest r with r*r*var <= 2^24, so var of zero gives all ones.
*/
`timescale 1ns/1ns

module isqrt_seq (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [gn_pkg::VAR_W-1:0]   var_in,
  input  logic                       in_valid,
  output logic                       in_ready,
  output logic [gn_pkg::ISQRT_W-1:0] isqrt,
  output logic                       out_valid,
  input  logic                       out_ready
);

  import gn_pkg::*;

  localparam int PROD_W = 2 * ISQRT_W + VAR_W;
  // r and var carry 8 fraction bits each, so 1.0 sits at bit 24
  localparam logic [PROD_W-1:0] LIMIT = PROD_W'(1) << (3 * ISQRT_FRAC);

  logic [VAR_W-1:0]   var_q;
  logic [ISQRT_W-1:0] bit_mask;
  logic [ISQRT_W-1:0] trial;
  logic [PROD_W-1:0]  prod;
  logic               in_fire;

  assign trial    = isqrt | bit_mask;
  assign prod     = PROD_W'(trial) * PROD_W'(trial) * PROD_W'(var_q);
  assign in_ready = !(|bit_mask) && !out_valid;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (in_fire) begin
      var_q <= var_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      isqrt     <= '0;
      bit_mask  <= '0;
      out_valid <= 1'b0;
    end else if (in_fire) begin
      isqrt    <= '0;
      bit_mask <= {1'b1, {(ISQRT_W-1){1'b0}}};
    end else if (|bit_mask) begin
      // Keep the trial bit only if the product stays within bound
      if (prod <= LIMIT) begin
        isqrt <= trial;
      end
      bit_mask <= bit_mask >> 1;
      if (bit_mask[0]) begin
        out_valid <= 1'b1;
      end
    end else if (out_valid && out_ready) begin
      out_valid <= 1'b0;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it.
# Exit status is nonzero if the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    --top-module group_norm_tb \
    -Mdir obj_dir \
    -f group_norm.f; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vgroup_norm_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit "$status"
fi

exit 0

// File: test/group_norm_chk.sv
/*
  Stream and APB protocol checks, bound into every group_norm_top.
*/
`timescale 1ns/1ns

module group_norm_chk (
  input logic             clk,
  input logic             rst_n,
  input gn_pkg::beat_t    out_beat,
  input logic             out_valid,
  input logic             out_ready,
  input gn_pkg::apb_req_t apb_req,
  input gn_pkg::apb_rsp_t apb_rsp
);

  // Output holds while stalled
  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("out_beat or out_valid changed while out_ready was low");

  reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high during reset");

  err_phase: assert property (@(posedge clk)
    apb_rsp.pslverr |-> apb_req.psel && apb_req.penable)
    else $error("pslverr high outside an APB access phase");

endmodule

bind group_norm_top group_norm_chk i_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_beat  (out_beat),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .apb_req   (apb_req),
  .apb_rsp   (apb_rsp)
);

// File: test/group_norm_tb.sv
/*
  Drives group_norm_top with GROUP_BEATS 4 and NUM_GROUPS 4 through APB and stream tests.
  Expected beats come from a reference model of the fixed-point rules.
  The gamma/beta registers are only changed while the pipeline is empty.
*/
`timescale 1ns/1ns

module group_norm_tb;

  import gn_pkg::*;

  localparam int GROUP_BEATS     = 4;
  localparam int NUM_GROUPS      = 4;
  localparam int N               = LANES * GROUP_BEATS;
  localparam int LOG2N           = $clog2(N);
  localparam int DRIVE_DLY       = 1;
  localparam int TOTAL_GROUPS    = 44;
  localparam int WATCHDOG_CYCLES = 400 * TOTAL_GROUPS + 2000;

  typedef beat_t [GROUP_BEATS-1:0] group_t;

  logic     clk;
  logic     rst_n;
  beat_t    in_beat;
  logic     in_valid;
  logic     in_ready;
  beat_t    out_beat;
  logic     out_valid;
  logic     out_ready;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  // Host-side copy of the gamma/beta registers
  data_t gamma_m [NUM_GROUPS];
  data_t beta_m  [NUM_GROUPS];
  beat_t exp_q [$];
  int    groups_sent;
  bit    stall_mode;

  group_norm_top #(
    .GROUP_BEATS (GROUP_BEATS),
    .NUM_GROUPS  (NUM_GROUPS)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic int clamp8(input int v);
    if (v > DATA_MAX) begin
      return DATA_MAX;
    end
    if (v < DATA_MIN) begin
      return DATA_MIN;
    end
    return v;
  endfunction

  // Expected output of one group through mean, variance, isqrt and affine
  function automatic group_t normalise_group(input group_t x, input data_t g, input data_t b);
    int     sum;
    int     mean;
    int     d;
    int     sq_sum;
    int     var_v;
    int     r;
    int     n;
    int     a;
    group_t y;
    sum    = 0;
    sq_sum = 0;
    for (int k = 0; k < GROUP_BEATS; k++) begin
      for (int i = 0; i < LANES; i++) begin
        sum += int'($signed(x[k][i]));
      end
    end
    mean = sum >>> LOG2N;
    for (int k = 0; k < GROUP_BEATS; k++) begin
      for (int i = 0; i < LANES; i++) begin
        d = int'($signed(x[k][i])) - mean;
        sq_sum += d * d;
      end
    end
    var_v = sq_sum >>> LOG2N;
    // Largest r with r*r*var <= 2^24
    r = 4095;
    while (r > 0 && longint'(r) * r * var_v > (longint'(1) << 24)) begin
      r--;
    end
    for (int k = 0; k < GROUP_BEATS; k++) begin
      for (int i = 0; i < LANES; i++) begin
        d = int'($signed(x[k][i])) - mean;
        n = clamp8((d * r) >>> ISQRT_FRAC);
        a = ((n * int'(g)) >>> FRAC_W) + int'(b);
        y[k][i] = data_t'(clamp8(a));
      end
    end
    return y;
  endfunction

  function automatic group_t random_group();
    int     sh;
    data_t  v;
    group_t y;
    // Random shift gives a spread of variances
    sh = int'($urandom_range(7, 0));
    for (int k = 0; k < GROUP_BEATS; k++) begin
      for (int i = 0; i < LANES; i++) begin
        v       = data_t'($urandom);
        y[k][i] = v >>> sh;
      end
    end
    return y;
  endfunction

  function automatic group_t const_group(input data_t v);
    group_t y;
    for (int k = 0; k < GROUP_BEATS; k++) begin
      for (int i = 0; i < LANES; i++) begin
        y[k][i] = v;
      end
    end
    return y;
  endfunction

  // Zeros with one maximum and one minimum value
  function automatic group_t wide_group();
    int     hi;
    int     lo;
    group_t y;
    y  = '0;
    hi = int'($urandom_range(N - 1, 0));
    lo = (hi + 1 + int'($urandom_range(N - 2, 0))) % N;
    y[hi / LANES][hi % LANES] = data_t'(DATA_MAX);
    y[lo / LANES][lo % LANES] = data_t'(DATA_MIN);
    return y;
  endfunction

  task automatic check_beat(input beat_t got, input beat_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAIL out_beat: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic check_apb(input string what, input apb_rsp_t got, input logic [31:0] exp_data,
                           input logic exp_err, input bit cmp_data);
    if (got.pready !== 1'b1) begin
      stop_with_failure($sformatf("FAIL %s pready: got 0x%h, expected 0x1", what, got.pready));
    end else if (got.pslverr !== exp_err) begin
      stop_with_failure($sformatf("FAIL %s pslverr: got 0x%h, expected 0x%h",
                                  what, got.pslverr, exp_err));
    end else if (cmp_data && got.prdata !== exp_data) begin
      stop_with_failure($sformatf("FAIL %s prdata: got 0x%h, expected 0x%h",
                                  what, got.prdata, exp_data));
    end
  endtask

  // Setup phase and an access phase sampled mid-cycle
  task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output apb_rsp_t rsp);
    @(posedge clk);
    #DRIVE_DLY;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DLY;
    apb_req.penable = 1'b1;
    @(negedge clk);
    rsp = apb_rsp;
    @(posedge clk);
    #DRIVE_DLY;
    apb_req = '0;
  endtask

  task automatic read_reg(input logic [7:0] addr);
    int          idx;
    bit          in_range;
    logic [31:0] exp_data;
    apb_rsp_t    rsp;
    idx      = int'(addr[7:2]);
    in_range = (idx < NUM_GROUPS);
    exp_data = in_range ? {16'h0, beta_m[idx], gamma_m[idx]} : 32'h0;
    apb_access(1'b0, addr, 32'h0, rsp);
    check_apb($sformatf("apb_rsp read 0x%h", addr), rsp, exp_data, !in_range, 1'b1);
  endtask

  task automatic write_reg(input logic [7:0] addr, input data_t g, input data_t b);
    int       idx;
    bit       in_range;
    apb_rsp_t rsp;
    idx      = int'(addr[7:2]);
    in_range = (idx < NUM_GROUPS);
    apb_access(1'b1, addr, {16'h0, b, g}, rsp);
    check_apb($sformatf("apb_rsp write 0x%h", addr), rsp, 32'h0, !in_range, 1'b0);
    if (in_range) begin
      gamma_m[idx] = g;
      beta_m[idx]  = b;
    end
  endtask

  // Queue the expected beats and hand the group over beat by beat
  task automatic send_group(input group_t grp, input int max_gap);
    int     idx;
    int     gap;
    group_t exp;
    idx = groups_sent % NUM_GROUPS;
    exp = normalise_group(grp, gamma_m[idx], beta_m[idx]);
    for (int k = 0; k < GROUP_BEATS; k++) begin
      exp_q.push_back(exp[k]);
    end
    groups_sent++;
    for (int k = 0; k < GROUP_BEATS; k++) begin
      gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
      repeat (gap) begin
        in_valid = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
      end
      in_beat  = grp[k];
      in_valid = 1'b1;
      @(negedge clk);
      while (!in_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
      #DRIVE_DLY;
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  // Random output stalls only while stall_mode is set
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      out_ready = stall_mode ? ($urandom_range(1, 0) == 1) : 1'b1;
    end
  end

  initial begin
    beat_t exp_b;
    forever begin
      @(negedge clk);
      if (rst_n && out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("Output beat appeared with no expected beat queued");
        end else begin
          exp_b = exp_q.pop_front();
          check_beat(out_beat, exp_b);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure("Watchdog timeout, the pipeline stopped making progress");
  end

  initial begin
    void'($urandom(32'h9aac_c0b7));
    rst_n       = 1'b1;
    in_beat     = '0;
    in_valid    = 1'b0;
    apb_req     = '0;
    stall_mode  = 1'b0;
    groups_sent = 0;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      gamma_m[g] = data_t'(8'h10);
      beta_m[g]  = '0;
    end
    // Falling edge so the async reset fires
    #DRIVE_DLY rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #DRIVE_DLY rst_n = 1'b1;
    @(negedge clk);
    if (!in_ready) begin
      stop_with_failure("in_ready did not rise after reset release");
    end else if (out_valid) begin
      stop_with_failure("out_valid is high right after reset");
    end
    @(posedge clk);
    #DRIVE_DLY;

    // APB reset values and unmapped addresses
    for (int g = 0; g < NUM_GROUPS; g++) begin
      read_reg(8'(4 * g));
    end
    read_reg(8'(4 * NUM_GROUPS));
    read_reg(8'hfc);
    write_reg(8'(4 * NUM_GROUPS), data_t'(8'h7f), data_t'(8'h33));
    read_reg(8'h00);

    // Identity affine
    repeat (8) send_group(random_group(), 0);
    wait_drained();

    // Own gamma and beta per group
    for (int g = 0; g < NUM_GROUPS; g++) begin
      write_reg(8'(4 * g), data_t'($urandom), data_t'($urandom));
    end
    for (int g = 0; g < NUM_GROUPS; g++) begin
      read_reg(8'(4 * g));
    end
    repeat (8) send_group(random_group(), 0);
    wait_drained();

    // Zero variance and saturation at both ends with a large gamma
    for (int g = 0; g < NUM_GROUPS; g++) begin
      write_reg(8'(4 * g), data_t'(8'h7f), data_t'($urandom));
    end
    send_group(const_group(data_t'(8'h80)), 0);
    send_group(wide_group(), 0);
    send_group(const_group(data_t'(8'h7f)), 0);
    send_group(wide_group(), 0);
    wait_drained();

    // Random stalls and input gaps
    for (int g = 0; g < NUM_GROUPS; g++) begin
      write_reg(8'(4 * g), data_t'($urandom), data_t'($urandom));
    end
    stall_mode = 1'b1;
    repeat (24) send_group(random_group(), 3);
    wait_drained();
    stall_mode = 1'b0;

    // Nothing left in flight once every expected beat is out
    @(negedge clk);
    if (out_valid || !in_ready) begin
      stop_with_failure("Pipeline not idle after the last expected output beat");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule
